// ==== src/initialSequence.hex ====
// One two-bit move per line in hex, sequence memory addresses 0 to 15
0
2
1
3
3
0
2
1
1
2
0
3
2
3
1
0

// ==== sequenceGame.f ====
common/sequenceGamePkg.sv
gameDatapath/sequenceMemory.sv
gameDatapath/gameDatapath.sv
gameControl/gameControl.sv
src/sequenceGame.sv
sim/sequenceGameTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the sequence game testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module sequenceGameTb -f sequenceGame.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VsequenceGameTb > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -qx "Simulation finished: PASS" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1

// ==== sim/sequenceGameTb.sv ====
// Sequence game testbench that checks a random player against a reference game model
`default_nettype none

module sequenceGameTb import sequenceGamePkg::*; ();

    logic        clock;
    logic        reset;
    logic        start;
    logic        levelRounds;
    logic        levelTime;
    logic        moveReq;
    move_t       moveValue;
    logic        moveAck;
    logic [3:0]  leds;
    gameStatus_t status;
    gameState_t  state;

    integer seed;
    int     gameCount;
    int     checkCount;
    int     mismatchErrors;
    int     otherErrors;
    int     gamesWon;
    int     gamesLost;
    int     gamesTimedOut;
    logic   lastAck;
    logic   lastReq;
    // Reference copy of the sequence memory
    move_t  model [2**addrWidth];

    sequenceGame u_dut (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .levelRounds (levelRounds),
        .levelTime   (levelTime),
        .moveReq     (moveReq),
        .moveValue   (moveValue),
        .moveAck     (moveAck),
        .leds        (leds),
        .status      (status),
        .state       (state)
    );

    always #10 clock = ~clock;

    // ------------------------------------------------------------------
    // Helpers
    function automatic int randomBelow(input int limit);
        int value;
        value = $random(seed);
        return (value & 32'h7fff_ffff) % limit;
    endfunction

    // Inputs change and outputs are read 2 units after the edge
    task automatic stepCycle();
        @(posedge clock);
        #2;
    endtask

    task automatic compareValue(input int actual, input int expected, input string what);
        checkCount++;
        assert (actual == expected) else begin
            mismatchErrors++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic checkCondition(input logic condition, input string problem);
        checkCount++;
        assert (condition) else begin
            otherErrors++;
            $display("ERROR at %0t: %s", $time, problem);
        end
    endtask

    task automatic reportCounts();
        $display("Checks %0d, mismatches %0d, other errors %0d, won %0d, lost %0d, timed out %0d",
                 checkCount, mismatchErrors, otherErrors, gamesWon, gamesLost, gamesTimedOut);
    endtask

    task automatic abortRun(input string reason);
        $display("ERROR at %0t: %s (state %0d)", $time, reason, state);
        reportCounts();
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic waitForAck(input logic level);
        int waited;
        waited = 0;
        while (moveAck != level) begin
            if (waited == 8) abortRun("moveAck did not follow moveReq");
            stepCycle();
            waited++;
        end
    endtask

    task automatic waitForTurn(input logic newMoveTurn);
        int waited;
        waited = 0;
        while (!(newMoveTurn ? status.newMove : status.playerTurn)) begin
            if (waited == 8) abortRun("DUT never asked for the next move");
            stepCycle();
            waited++;
        end
    endtask

    // Four-phase handshake for one move
    task automatic playMove(input move_t value, input logic playerMove);
        checkCondition(!moveAck, "moveAck high before a new request");
        moveValue = value;
        moveReq   = 1'b1;
        waitForAck(1'b1);
        moveReq = 1'b0;
        waitForAck(1'b0);
        if (playerMove) begin
            compareValue(int'(leds), int'(4'b0001 << value), "leds in compare phase");
        end
        moveValue = move_t'(randomBelow(4));
    endtask

    // Record lit LED runs until the player gets the turn
    task automatic readDisplay(input int round);
        logic [3:0] shown [maxRounds];
        logic [3:0] previous;
        int         count;
        int         litLength;
        int         waited;
        int         k;
        previous  = 4'b0000;
        count     = 0;
        litLength = 0;
        waited    = 0;
        while (!status.playerTurn) begin
            if (waited > (round + 1) * (showCycles + gapCycles) + 8) begin
                abortRun("display phase did not hand over to the player");
            end
            stepCycle();
            waited++;
            if (leds != 4'b0000 && previous == 4'b0000) begin
                if (count < maxRounds) shown[count] = leds;
                count++;
                litLength = 1;
            end else if (leds != 4'b0000) begin
                checkCondition(leds == previous, "LED pattern changed within one shown move");
                litLength++;
            end else if (previous != 4'b0000) begin
                compareValue(litLength, showCycles, "lit cycles of a shown move");
            end
            previous = leds;
        end
        compareValue(count, round + 1, "number of shown moves");
        for (k = 0; k < count && k < maxRounds && k <= round; k++) begin
            compareValue(int'(shown[k]), int'(4'b0001 << model[k]),
                         $sformatf("shown move %0d of round %0d", k, round));
        end
    endtask

    task automatic checkOutcome(input logic wonExpected, input logic lostExpected,
                                input logic timedOutExpected);
        int         waited;
        gameState_t endState;
        waited = 0;
        if (wonExpected) begin
            endState = wonGame;
        end else if (timedOutExpected) begin
            endState = timeoutGame;
        end else begin
            endState = lostGame;
        end
        while (!status.ready) begin
            if (waited == 2 * timeoutCycles + 16) abortRun("game did not end");
            stepCycle();
            waited++;
        end
        compareValue(int'(status.won), int'(wonExpected), "won");
        compareValue(int'(status.lost), int'(lostExpected), "lost");
        compareValue(int'(status.timedOut), int'(timedOutExpected), "timedOut");
        compareValue(int'(state), int'(endState), "state at game end");
    endtask

    // ------------------------------------------------------------------
    // One game with random levels and random player choices
    task automatic playGame();
        int    round;
        int    move;
        int    lastIndex;
        int    choice;
        logic  over;
        move_t value;
        levelRounds = randomBelow(2) == 1;
        levelTime   = randomBelow(2) == 1;
        lastIndex   = levelRounds ? maxRounds - 1 : halfRounds - 1;
        checkCondition(status.ready, "DUT not ready at game start");
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        round = 0;
        over  = 1'b0;
        while (!over) begin
            readDisplay(round);
            for (move = 0; move <= round && !over; move++) begin
                waitForTurn(1'b0);
                choice = randomBelow(1000);
                if (choice < 3) begin
                    // Far past the full limit
                    checkOutcome(1'b0, 1'b1, 1'b1);
                    gamesTimedOut++;
                    over = 1'b1;
                end else if (choice < 10) begin
                    value = model[move] ^ move_t'(randomBelow(3) + 1);
                    repeat (randomBelow(8)) stepCycle();
                    playMove(value, 1'b1);
                    checkOutcome(1'b0, 1'b1, 1'b0);
                    gamesLost++;
                    over = 1'b1;
                end else begin
                    repeat (randomBelow(8)) stepCycle();
                    playMove(model[move], 1'b1);
                end
            end
            if (!over && round == lastIndex) begin
                checkOutcome(1'b1, 1'b0, 1'b0);
                gamesWon++;
                over = 1'b1;
            end else if (!over) begin
                waitForTurn(1'b1);
                value = move_t'(randomBelow(4));
                repeat (randomBelow(8)) stepCycle();
                playMove(value, 1'b0);
                model[round + 1] = value;
                round++;
            end
        end
    endtask

    // Handshake order seen between falling edges
    always @(negedge clock) begin
        if (!reset) begin
            if (moveAck && !lastAck) checkCondition(lastReq, "moveAck rose without moveReq");
            if (!moveAck && lastAck) checkCondition(!lastReq, "moveAck fell with moveReq high");
        end
        lastAck = moveAck;
        lastReq = moveReq;
    end

    initial begin : watchdog
        int limitCycles;
        limitCycles = 12 * maxRounds * maxRounds * (showCycles + gapCycles + timeoutCycles);
        repeat (limitCycles) @(posedge clock);
        abortRun("watchdog expired before all games finished");
    end

    initial begin : mainSequence
        int game;
        seed           = 17;
        gameCount      = 12;
        checkCount     = 0;
        mismatchErrors = 0;
        otherErrors    = 0;
        gamesWon       = 0;
        gamesLost      = 0;
        gamesTimedOut  = 0;
        lastAck        = 1'b0;
        lastReq        = 1'b0;
        clock          = 1'b0;
        reset          = 1'b1;
        start          = 1'b0;
        levelRounds    = 1'b0;
        levelTime      = 1'b0;
        moveReq        = 1'b0;
        moveValue      = '0;
        $readmemh("src/initialSequence.hex", model);
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        compareValue(int'(status.ready), 1, "ready after reset");
        compareValue(int'(leds), 0, "leds after reset");
        compareValue(int'(moveAck), 0, "moveAck after reset");
        compareValue(int'(status.won | status.lost | status.timedOut), 0, "end flags after reset");
        compareValue(int'(status.playerTurn | status.newMove), 0, "turn flags after reset");
        compareValue(int'(state), int'(idle), "state after reset");
        for (game = 0; game < gameCount; game++) begin
            playGame();
        end
        reportCounts();
        if (mismatchErrors == 0 && otherErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/sequenceGame.sv ====
// Sequence game top level joining the control unit and the datapath
`default_nettype none

module sequenceGame import sequenceGamePkg::*; (
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire logic  start,
    input  wire logic  levelRounds,
    input  wire logic  levelTime,
    input  wire logic  moveReq,
    input  wire move_t moveValue,
    output logic       moveAck,
    output logic [3:0] leds,
    output gameStatus_t status,
    output gameState_t  state
);

    controlSignals_t   controls;
    conditionSignals_t conditions;

    // ------------------------------------------------------------------
    // Control unit
    gameControl uControl (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .moveReq    (moveReq),
        .conditions (conditions),
        .controls   (controls),
        .status     (status),
        .moveAck    (moveAck),
        .state      (state)
    );

    // ------------------------------------------------------------------
    // Datapath
    gameDatapath uDatapath (
        .clock       (clock),
        .reset       (reset),
        .controls    (controls),
        .levelRounds (levelRounds),
        .levelTime   (levelTime),
        .moveValue   (moveValue),
        .conditions  (conditions),
        .leds        (leds)
    );

endmodule

`default_nettype wire

// ==== gameControl/gameControl.sv ====
// Game control unit, a Moore FSM that runs display, player input, compare and game end
`default_nettype none

module gameControl import sequenceGamePkg::*; (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              start,
    input  wire logic              moveReq,
    input  wire conditionSignals_t conditions,
    output controlSignals_t        controls,
    output gameStatus_t            status,
    output logic                   moveAck,
    output gameState_t             state
);

    gameState_t nextState;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    // ------------------------------------------------------------------
    // Next state
    always_comb begin
        nextState = state;
        unique case (state)
            idle:           if (start) nextState = initGame;
            initGame:       nextState = roundStart;
            roundStart:     nextState = showMove;
            showMove:       if (conditions.timerShowDone) nextState = showGap;
            showGap:        if (conditions.timerGapDone) nextState = nextShow;
            // Last shown move hands over to the player
            nextShow:       nextState = conditions.addressAtRound ? playerWait : showMove;
            playerWait: begin
                if (conditions.moveTimeout) begin
                    nextState = timeoutGame;
                end else if (moveReq) begin
                    nextState = acceptMove;
                end
            end
            acceptMove:     nextState = moveReq ? releaseMove : compareMove;
            releaseMove:    if (!moveReq) nextState = compareMove;
            compareMove: begin
                if (!conditions.moveCorrect) begin
                    nextState = lostGame;
                end else if (!conditions.addressAtRound) begin
                    nextState = nextMove;
                end else if (conditions.lastRound) begin
                    nextState = wonGame;
                end else begin
                    nextState = newMoveWait;
                end
            end
            nextMove:       nextState = playerWait;
            newMoveWait:    if (moveReq) nextState = newMoveAccept;
            newMoveAccept:  nextState = moveReq ? newMoveRelease : nextRound;
            newMoveRelease: if (!moveReq) nextState = nextRound;
            nextRound:      nextState = roundStart;
            wonGame, lostGame, timeoutGame: begin
                if (start) nextState = initGame;
            end
            default:        nextState = idle;
        endcase
    end

    // ------------------------------------------------------------------
    // Moore outputs
    always_comb begin
        controls = '0;
        unique case (state)
            initGame: begin
                controls.clearAddress   = 1'b1;
                controls.clearRound     = 1'b1;
                controls.clearTimer     = 1'b1;
                controls.clearMoveTimer = 1'b1;
                controls.captureLevel   = 1'b1;
            end
            roundStart: begin
                controls.clearAddress   = 1'b1;
                controls.clearTimer     = 1'b1;
                controls.clearMoveTimer = 1'b1;
            end
            showMove: begin
                controls.runTimer   = 1'b1;
                controls.showMemory = 1'b1;
            end
            showGap:       controls.runTimer = 1'b1;
            nextShow: begin
                controls.stepAddress = 1'b1;
                controls.clearTimer  = 1'b1;
            end
            playerWait:    controls.runMoveTimer = 1'b1;
            acceptMove:    controls.captureMove = 1'b1;
            compareMove:   controls.showPlayer = 1'b1;
            nextMove: begin
                controls.stepAddress    = 1'b1;
                controls.clearMoveTimer = 1'b1;
            end
            newMoveAccept: controls.captureMove = 1'b1;
            // Write at round + 1 before the round counter moves
            nextRound: begin
                controls.writeMove = 1'b1;
                controls.stepRound = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        status            = '0;
        status.ready      = (state == idle) || (state == wonGame)
                         || (state == lostGame) || (state == timeoutGame);
        status.playerTurn = (state == playerWait);
        status.newMove    = (state == newMoveWait);
        status.won        = (state == wonGame);
        status.lost       = (state == lostGame) || (state == timeoutGame);
        status.timedOut   = (state == timeoutGame);
    end

    assign moveAck = (state == acceptMove) || (state == releaseMove)
                  || (state == newMoveAccept) || (state == newMoveRelease);

    // Handshake order as seen by the player
    ackFollowsReq: assert property (@(posedge clock) disable iff (reset)
        $rose(moveAck) |-> $past(moveReq));

    wonLostExclusive: assert property (@(posedge clock) disable iff (reset)
        !(status.won && status.lost));

endmodule

`default_nettype wire

// ==== gameDatapath/gameDatapath.sv ====
// Game datapath with counters, timers, level and move registers and the move comparator
`default_nettype none

module gameDatapath import sequenceGamePkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire controlSignals_t controls,
    input  wire logic            levelRounds,
    input  wire logic            levelTime,
    input  wire move_t           moveValue,
    output conditionSignals_t    conditions,
    output logic [3:0]           leds
);

    logic [addrWidth-1:0]      address;
    logic [addrWidth-1:0]      round;
    logic [addrWidth-1:0]      lastRoundIndex;
    logic [addrWidth-1:0]      memAddress;
    logic [showTimerWidth-1:0] showTimer;
    logic [moveTimerWidth-1:0] moveTimer;
    logic [moveTimerWidth-1:0] moveLimit;
    logic                      longGame;
    logic                      halfTime;
    logic                      addressAtRound;
    move_t                     playerMove;
    move_t                     storedMove;

    assign addressAtRound = (address == round);

    // ------------------------------------------------------------------
    // Counters
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            address <= '0;
        end else if (controls.clearAddress) begin
            address <= '0;
        end else if (controls.stepAddress) begin
            // Wraps after the last move of the round
            address <= addressAtRound ? '0 : address + 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            round <= '0;
        end else if (controls.clearRound) begin
            round <= '0;
        end else if (controls.stepRound) begin
            round <= round + 1'b1;
        end
    end

    // Display timer, runs on through lit and dark phases
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            showTimer <= '0;
        end else if (controls.clearTimer) begin
            showTimer <= '0;
        end else if (controls.runTimer) begin
            showTimer <= showTimer + 1'b1;
        end
    end

    // Move timer holds at its limit
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            moveTimer <= '0;
        end else if (controls.clearMoveTimer) begin
            moveTimer <= '0;
        end else if (controls.runMoveTimer && moveTimer != moveLimit) begin
            moveTimer <= moveTimer + 1'b1;
        end
    end

    // Level bits, 1 selects 16 rounds and the half timeout
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            longGame <= 1'b0;
            halfTime <= 1'b0;
        end else if (controls.captureLevel) begin
            longGame <= levelRounds;
            halfTime <= levelTime;
        end
    end

    always_ff @(posedge clock) begin
        if (controls.captureMove) begin
            playerMove <= moveValue;
        end
    end

    // ------------------------------------------------------------------
    // Memory and conditions
    assign memAddress = controls.writeMove ? round + 1'b1 : address;

    sequenceMemory uMemory (
        .clock       (clock),
        .writeEnable (controls.writeMove),
        .address     (memAddress),
        .writeData   (playerMove),
        .readData    (storedMove)
    );

    assign lastRoundIndex = longGame ? addrWidth'(maxRounds - 1) : addrWidth'(halfRounds - 1);
    assign moveLimit      = halfTime ? moveTimerWidth'(timeoutCycles / 2)
                                     : moveTimerWidth'(timeoutCycles);

    assign conditions.timerShowDone  = (showTimer == showTimerWidth'(showCycles - 1));
    // One gap cycle is spent in the step state
    assign conditions.timerGapDone   = (showTimer == showTimerWidth'(showCycles + gapCycles - 2));
    assign conditions.moveTimeout    = (moveTimer == moveLimit);
    assign conditions.moveCorrect    = (playerMove == storedMove);
    assign conditions.addressAtRound = addressAtRound;
    assign conditions.lastRound      = (round == lastRoundIndex);

    always_comb begin
        leds = 4'b0000;
        if (controls.showMemory) begin
            leds = 4'b0001 << storedMove;
        end else if (controls.showPlayer) begin
            leds = 4'b0001 << playerMove;
        end
    end

    addressWithinRound: assert property (@(posedge clock) disable iff (reset)
        address <= round);

endmodule

`default_nettype wire

// ==== gameDatapath/sequenceMemory.sv ====
// Move memory, synchronous write and combinational read, preloaded with a start sequence
`default_nettype none

module sequenceMemory import sequenceGamePkg::*; (
    input  wire logic                 clock,
    input  wire logic                 writeEnable,
    input  wire logic [addrWidth-1:0] address,
    input  wire move_t                writeData,
    output move_t                     readData
);

    move_t memory [2**addrWidth];

    // Preload path is relative to the project root
    initial begin
        $readmemh("src/initialSequence.hex", memory);
    end

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            memory[address] <= writeData;
        end
    end

    assign readData = memory[address];

endmodule

`default_nettype wire

// ==== common/sequenceGamePkg.sv ====
// Sequence game shared sizes, move and state types, and the structs between blocks
package sequenceGamePkg;

    // Game length and display timing
    localparam int maxRounds     = 16;
    localparam int halfRounds    = 8;
    localparam int showCycles    = 8;
    localparam int gapCycles     = 4;
    localparam int timeoutCycles = 64;

    // Widths
    localparam int addrWidth      = 4;
    localparam int showTimerWidth = $clog2(showCycles + gapCycles);
    localparam int moveTimerWidth = $clog2(timeoutCycles + 1);

    // One move, a color index shown one-hot on the LEDs
    typedef logic [1:0] move_t;

    typedef enum logic [4:0] {
        idle           = 5'd0,
        initGame       = 5'd1,
        roundStart     = 5'd2,
        showMove       = 5'd3,
        showGap        = 5'd4,
        nextShow       = 5'd5,
        playerWait     = 5'd6,
        acceptMove     = 5'd7,
        releaseMove    = 5'd8,
        compareMove    = 5'd9,
        nextMove       = 5'd10,
        newMoveWait    = 5'd11,
        newMoveAccept  = 5'd12,
        newMoveRelease = 5'd13,
        nextRound      = 5'd14,
        wonGame        = 5'd15,
        lostGame       = 5'd16,
        timeoutGame    = 5'd17
    } gameState_t;

    // ------------------------------------------------------------------
    // Control to datapath
    typedef struct packed {
        logic clearAddress;
        logic stepAddress;
        logic clearRound;
        logic stepRound;
        logic clearTimer;
        logic runTimer;
        logic clearMoveTimer;
        logic runMoveTimer;
        logic captureLevel;
        logic captureMove;
        logic writeMove;
        logic showMemory;
        logic showPlayer;
    } controlSignals_t;

    // Datapath back to control
    typedef struct packed {
        logic timerShowDone;
        logic timerGapDone;
        logic moveTimeout;
        logic moveCorrect;
        logic addressAtRound;
        logic lastRound;
    } conditionSignals_t;

    // Game outputs seen by the player
    typedef struct packed {
        logic ready;
        logic playerTurn;
        logic newMove;
        logic won;
        logic lost;
        logic timedOut;
    } gameStatus_t;

endpackage
